//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mix_transpose
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
GOLDEN    := mix_transpose_golden.txt

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter-out +%,$(shell cat $(FILELIST))) mix_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+.
mix_data_pkg.sv
mix_ctrl_pkg.sv
mix_word_ram.sv
mix_transpose.sv
mix_seq.sv
mix_transpose_top.sv
tb_mix_transpose.sv

//--- mix_ctrl_pkg.sv
package mix_ctrl_pkg;

  // sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_FINISH
  } seq_state_t;

endpackage

//--- mix_data_pkg.sv
`include "mix_params.svh"

package mix_data_pkg;

  // one matrix element
  typedef logic [`N_LEN_W-1:0] elem_t;

  // packed word, element 0 sits in the low bits
  typedef elem_t [`DATA_N-1:0] word_t;

endpackage

//--- mix_params.svh
`ifndef MIX_PARAMS_SVH
`define MIX_PARAMS_SVH

// ----------------------------------------------------------------------
// matrix geometry
// ----------------------------------------------------------------------
`define HID_DIM 8
`define DATA_N 4
`define N_LEN_W 8
`define MAT_CNT 3

// ----------------------------------------------------------------------
// buffer sizes
// ----------------------------------------------------------------------
// words per matrix, row-major, DATA_N elements per word
`define WORDS_PER_MAT (`HID_DIM * `HID_DIM / `DATA_N)
`define BUF_WORDS (`MAT_CNT * `WORDS_PER_MAT)
// enough for BUF_WORDS
`define BUF_AW 6

`endif

//--- mix_seq.sv
module mix_seq (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic valid,
  output logic run,
  output logic wr_en,
  output logic busy,
  output logic done
);

  mix_ctrl_pkg::seq_state_t state;
  mix_ctrl_pkg::seq_state_t state_nxt;

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      mix_ctrl_pkg::SEQ_IDLE: begin
        if (start) begin
          state_nxt = mix_ctrl_pkg::SEQ_RUN;
        end
      end
      mix_ctrl_pkg::SEQ_RUN: begin
        // start is ignored here
        if (valid) begin
          state_nxt = mix_ctrl_pkg::SEQ_FINISH;
        end
      end
      mix_ctrl_pkg::SEQ_FINISH: begin
        state_nxt = mix_ctrl_pkg::SEQ_IDLE;
      end
      default: begin
        state_nxt = mix_ctrl_pkg::SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mix_ctrl_pkg::SEQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  assign run   = (state == mix_ctrl_pkg::SEQ_RUN);
  assign busy  = (state == mix_ctrl_pkg::SEQ_RUN);
  // last word already written once valid is up
  assign wr_en = (state == mix_ctrl_pkg::SEQ_RUN) & ~valid;
  assign done  = (state == mix_ctrl_pkg::SEQ_FINISH);

endmodule

//--- mix_transpose.sv
`include "mix_params.svh"

module mix_transpose (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  output logic                valid,
  output logic [`BUF_AW-1:0]  waddr,
  output mix_data_pkg::word_t wdata,
  output logic [`BUF_AW-1:0]  raddr,
  input  mix_data_pkg::word_t rdata
);

  // words per matrix row, also the number of row blocks
  localparam int WPR    = `HID_DIM / `DATA_N;
  localparam int ROW_W  = $clog2(`HID_DIM);
  localparam int BLK_W  = (WPR > 1) ? $clog2(WPR) : 1;
  localparam int SLOT_W = $clog2(`DATA_N);
  localparam int MAT_W  = (`MAT_CNT > 1) ? $clog2(`MAT_CNT) : 1;

  // read walk
  logic [ROW_W-1:0]    rd_row;
  logic [BLK_W-1:0]    rd_col;
  logic [MAT_W-1:0]    rd_mat;
  logic                rd_done;
  logic                rd_act;
  logic                rd_last;

  // write walk
  logic [SLOT_W-1:0]   wr_i;
  logic [BLK_W-1:0]    wr_rb;
  logic [BLK_W-1:0]    wr_col;
  logic [MAT_W-1:0]    wr_mat;
  logic [`BUF_AW-1:0]  wr_addr;
  logic                wr_end;
  logic                wr_last;

  // gather side
  logic                gat_we;
  logic [SLOT_W-1:0]   gat_slot;
  logic                blk_full;
  mix_data_pkg::word_t gather  [`DATA_N];
  mix_data_pkg::word_t out_buf [`DATA_N];

  // write pipe
  logic [`BUF_AW-1:0]  wa_pipe  [0:`DATA_N];
  logic [SLOT_W-1:0]   sel_pipe [0:`DATA_N];
  logic [`DATA_N+1:0]  last_pipe;
  logic [SLOT_W-1:0]   wr_sel;
  logic                wr_done;

  // ----------------------------------------------------------------------
  // read address walk, down each block column
  // ----------------------------------------------------------------------
  assign rd_act  = run & ~rd_done;
  assign rd_last = (rd_row == ROW_W'(`HID_DIM - 1)) & (rd_col == BLK_W'(WPR - 1))
                 & (rd_mat == MAT_W'(`MAT_CNT - 1));
  assign raddr   = `BUF_AW'(rd_mat * `WORDS_PER_MAT + rd_row * WPR + rd_col);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_row  <= '0;
      rd_col  <= '0;
      rd_mat  <= '0;
      rd_done <= 1'b0;
    end else if (!run) begin
      rd_row  <= '0;
      rd_col  <= '0;
      rd_mat  <= '0;
      rd_done <= 1'b0;
    end else if (rd_act) begin
      if (rd_last) begin
        rd_done <= 1'b1;
      end else if (rd_row != ROW_W'(`HID_DIM - 1)) begin
        rd_row <= rd_row + 1'b1;
      end else begin
        rd_row <= '0;
        if (rd_col != BLK_W'(WPR - 1)) begin
          rd_col <= rd_col + 1'b1;
        end else begin
          rd_col <= '0;
          rd_mat <= rd_mat + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // gather returning rows, latch transposed block
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gat_we   <= 1'b0;
      gat_slot <= '0;
      blk_full <= 1'b0;
    end else if (!run) begin
      gat_we   <= 1'b0;
      gat_slot <= '0;
      blk_full <= 1'b0;
    end else begin
      // rdata trails raddr by one cycle
      gat_we   <= rd_act;
      blk_full <= gat_we & (gat_slot == SLOT_W'(`DATA_N - 1));
      if (gat_we) begin
        if (gat_slot == SLOT_W'(`DATA_N - 1)) begin
          gat_slot <= '0;
        end else begin
          gat_slot <= gat_slot + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gat_we) begin
      gather[gat_slot] <= rdata;
    end
    // word i of the block holds element i of every gathered row
    if (blk_full) begin
      for (int i = 0; i < `DATA_N; i++) begin
        for (int j = 0; j < `DATA_N; j++) begin
          out_buf[i][j] <= gather[j][i];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // write address walk, mirrored blocks
  // ----------------------------------------------------------------------
  assign wr_end  = (wr_i == SLOT_W'(`DATA_N - 1)) & (wr_rb == BLK_W'(WPR - 1))
                 & (wr_col == BLK_W'(WPR - 1)) & (wr_mat == MAT_W'(`MAT_CNT - 1));
  assign wr_last = rd_act & wr_end;
  assign wr_addr = `BUF_AW'(wr_mat * `WORDS_PER_MAT + (wr_col * `DATA_N + wr_i) * WPR + wr_rb);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_i   <= '0;
      wr_rb  <= '0;
      wr_col <= '0;
      wr_mat <= '0;
    end else if (!run) begin
      wr_i   <= '0;
      wr_rb  <= '0;
      wr_col <= '0;
      wr_mat <= '0;
    end else if (rd_act && !wr_end) begin
      if (wr_i != SLOT_W'(`DATA_N - 1)) begin
        wr_i <= wr_i + 1'b1;
      end else begin
        wr_i <= '0;
        if (wr_rb != BLK_W'(WPR - 1)) begin
          wr_rb <= wr_rb + 1'b1;
        end else begin
          wr_rb <= '0;
          if (wr_col != BLK_W'(WPR - 1)) begin
            wr_col <= wr_col + 1'b1;
          end else begin
            wr_col <= '0;
            wr_mat <= wr_mat + 1'b1;
          end
        end
      end
    end
  end

  // delay so each address meets its latched block word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s <= `DATA_N; s++) begin
        wa_pipe[s]  <= '0;
        sel_pipe[s] <= '0;
      end
      last_pipe <= '0;
      waddr     <= '0;
      wr_sel    <= '0;
      wr_done   <= 1'b0;
    end else if (!run) begin
      for (int s = 0; s <= `DATA_N; s++) begin
        wa_pipe[s]  <= '0;
        sel_pipe[s] <= '0;
      end
      last_pipe <= '0;
      waddr     <= '0;
      wr_sel    <= '0;
      wr_done   <= 1'b0;
    end else begin
      wa_pipe[0]  <= wr_addr;
      sel_pipe[0] <= wr_i;
      for (int s = 1; s <= `DATA_N; s++) begin
        wa_pipe[s]  <= wa_pipe[s-1];
        sel_pipe[s] <= sel_pipe[s-1];
      end
      waddr     <= wa_pipe[`DATA_N];
      wr_sel    <= sel_pipe[`DATA_N];
      last_pipe <= {last_pipe[`DATA_N:0], wr_last};
      // top bit lines up with the last waddr
      wr_done   <= wr_done | last_pipe[`DATA_N+1];
    end
  end

  assign wdata = out_buf[wr_sel];
  assign valid = run & wr_done;

endmodule

//--- mix_transpose_golden.txt
// columns: buffer index, source word, expected destination word (hex)
// element 0 sits in the low byte of each word
00 03020100 30201000
01 07060504 70605040
02 13121110 31211101
03 17161514 71615141
04 23222120 32221202
05 27262524 72625242
06 33323130 33231303
07 37363534 73635343
08 43424140 34241404
09 47464544 74645444
0A 53525150 35251505
0B 57565554 75655545
0C 63626160 36261606
0D 67666564 76665646
0E 73727170 37271707
0F 77767574 77675747
10 0B0A0908 38281808
11 0F0E0D0C 78685848
12 1B1A1918 39291909
13 1F1E1D1C 79695949
14 2B2A2928 3A2A1A0A
15 2F2E2D2C 7A6A5A4A
16 3B3A3938 3B2B1B0B
17 3F3E3D3C 7B6B5B4B
18 4B4A4948 3C2C1C0C
19 4F4E4D4C 7C6C5C4C
1A 5B5A5958 3D2D1D0D
1B 5F5E5D5C 7D6D5D4D
1C 6B6A6968 3E2E1E0E
1D 6F6E6D6C 7E6E5E4E
1E 7B7A7978 3F2F1F0F
1F 7F7E7D7C 7F6F5F4F
20 83828180 B0A09080
21 87868584 F0E0D0C0
22 93929190 B1A19181
23 97969594 F1E1D1C1
24 A3A2A1A0 B2A29282
25 A7A6A5A4 F2E2D2C2
26 B3B2B1B0 B3A39383
27 B7B6B5B4 F3E3D3C3
28 C3C2C1C0 B4A49484
29 C7C6C5C4 F4E4D4C4
2A D3D2D1D0 B5A59585
2B D7D6D5D4 F5E5D5C5
2C E3E2E1E0 B6A69686
2D E7E6E5E4 F6E6D6C6
2E F3F2F1F0 B7A79787
2F F7F6F5F4 F7E7D7C7

//--- mix_transpose_top.sv
`include "mix_params.svh"

module mix_transpose_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                busy,
  output logic                done,
  input  logic                load_en,
  input  logic [`BUF_AW-1:0]  load_addr,
  input  mix_data_pkg::word_t load_data,
  input  logic [`BUF_AW-1:0]  rd_addr,
  output mix_data_pkg::word_t rd_data
);

  logic [`BUF_AW-1:0]  src_raddr;
  mix_data_pkg::word_t src_rdata;
  logic [`BUF_AW-1:0]  dst_waddr;
  mix_data_pkg::word_t dst_wdata;
  logic                dst_we;
  logic                run;
  logic                valid;

  // ----------------------------------------------------------------------
  // buffers
  // ----------------------------------------------------------------------
  // source, written by the host
  mix_word_ram #(
    .payload_t (mix_data_pkg::word_t),
    .DEPTH     (`BUF_WORDS)
  ) u_src_ram (
    .clk   (clk),
    .we    (load_en),
    .waddr (load_addr),
    .wdata (load_data),
    .raddr (src_raddr),
    .rdata (src_rdata)
  );

  // destination, read back by the host
  mix_word_ram #(
    .payload_t (mix_data_pkg::word_t),
    .DEPTH     (`BUF_WORDS)
  ) u_dst_ram (
    .clk   (clk),
    .we    (dst_we),
    .waddr (dst_waddr),
    .wdata (dst_wdata),
    .raddr (rd_addr),
    .rdata (rd_data)
  );

  // ----------------------------------------------------------------------
  // engine and control
  // ----------------------------------------------------------------------
  mix_transpose u_transpose (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .valid (valid),
    .waddr (dst_waddr),
    .wdata (dst_wdata),
    .raddr (src_raddr),
    .rdata (src_rdata)
  );

  mix_seq u_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .valid (valid),
    .run   (run),
    .wr_en (dst_we),
    .busy  (busy),
    .done  (done)
  );

endmodule

//--- mix_word_ram.sv
`include "mix_params.svh"

module mix_word_ram #(
  parameter type payload_t = mix_data_pkg::word_t,
  parameter int  DEPTH     = `BUF_WORDS
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  payload_t                 wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                 rdata
);

  payload_t mem [DEPTH];

  // single write port, registered read port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    // old data on a same-cycle collision
    rdata <= mem[raddr];
  end

endmodule

//--- tb_mix_transpose.sv
`include "mix_params.svh"

module tb_mix_transpose;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    WPR         = `HID_DIM / `DATA_N;
  localparam int    TIMEOUT     = 500;
  localparam string GOLDEN_FILE = "mix_transpose_golden.txt";

  logic                clk;
  logic                rst_n;
  logic                start;
  logic                busy;
  logic                done;
  logic                load_en;
  logic [`BUF_AW-1:0]  load_addr;
  mix_data_pkg::word_t load_data;
  logic [`BUF_AW-1:0]  rd_addr;
  mix_data_pkg::word_t rd_data;

  // index, source word, expected word per line
  logic [`DATA_N*`N_LEN_W-1:0] golden_mem [3*`BUF_WORDS];
  mix_data_pkg::word_t         src_words  [`BUF_WORDS];
  mix_data_pkg::word_t         exp_words  [`BUF_WORDS];
  integer                      seed;

  mix_transpose_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  always #10 clk = ~clk;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic load_source();
    for (int i = 0; i < `BUF_WORDS; i++) begin
      load_en   = 1'b1;
      load_addr = `BUF_AW'(i);
      load_data = src_words[i];
      step_cycle();
    end
    load_en = 1'b0;
  endtask

  // dst (m, r, c) takes src (m, c, r)
  function automatic void build_expected();
    for (int m = 0; m < `MAT_CNT; m++) begin
      for (int r = 0; r < `HID_DIM; r++) begin
        for (int c = 0; c < `HID_DIM; c++) begin
          exp_words[m*`WORDS_PER_MAT + r*WPR + c/`DATA_N][c%`DATA_N] =
            src_words[m*`WORDS_PER_MAT + c*WPR + r/`DATA_N][r%`DATA_N];
        end
      end
    end
  endfunction

  // start pulse, optional second start while busy, then wait for done
  task automatic run_transpose(input string name, input bit restart);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    start = 1'b1;
    step_cycle();
    start = 1'b0;
    check_value({name, " busy after start"}, 1, 32'(busy));
    if (restart) begin
      start = 1'b1;
      step_cycle();
      start = 1'b0;
    end
    while (!seen && cycles < TIMEOUT) begin
      step_cycle();
      cycles++;
      if (done) begin
        seen = 1'b1;
      end else begin
        check_value({name, " busy while running"}, 1, 32'(busy));
      end
    end
    if (!seen) begin
      stop_on_timeout({name, " done"});
    end
    check_value({name, " busy with done"}, 0, 32'(busy));
    // a single pulse, and no second run
    repeat (8) begin
      step_cycle();
      check_value({name, " done after pulse"}, 0, 32'(done));
      check_value({name, " busy after done"}, 0, 32'(busy));
    end
  endtask

  task automatic compare_destination(input string name);
    rd_addr = '0;
    step_cycle();
    for (int i = 0; i < `BUF_WORDS; i++) begin
      check_value($sformatf("%s word %0d", name, i), exp_words[i], rd_data);
      rd_addr = `BUF_AW'((i + 1) % `BUF_WORDS);
      step_cycle();
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    seed      = 91080;
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    rd_addr   = '0;
    $readmemh(GOLDEN_FILE, golden_mem);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle after reset
    check_value("reset busy", 0, 32'(busy));
    check_value("reset done", 0, 32'(done));
    repeat (4) begin
      step_cycle();
      check_value("idle busy", 0, 32'(busy));
      check_value("idle done", 0, 32'(done));
    end

    for (int i = 0; i < `BUF_WORDS; i++) begin
      check_value($sformatf("golden index %0d", i), i, golden_mem[3*i]);
      src_words[i] = golden_mem[3*i+1];
      exp_words[i] = golden_mem[3*i+2];
    end
    load_source();
    run_transpose("golden", 1'b0);
    compare_destination("golden");

    run_transpose("restart", 1'b1);
    compare_destination("restart");

    for (int i = 0; i < `BUF_WORDS; i++) begin
      src_words[i] = $random(seed);
    end
    build_expected();
    load_source();
    run_transpose("random", 1'b0);
    compare_destination("random");

    // source untouched so the same result is expected
    run_transpose("rerun", 1'b0);
    compare_destination("rerun");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
